// ==== bench/rs_patterns.txt ====
# All fields hex: D op dst rdy_a tag_a data_a rdy_b tag_b data_b, E tag data, F
# I cycles full_level, X tag result order (0 is any order); op 0 add 1 sub 2 and 3 or 4 xor 5 sll
# Every opcode with ready operands, back to back, results in dispatch order
X 0 23456789 1
X 1 fffffff0 2
X 2 f000f000 3
X 3 0f0f00ff 4
X 4 55555555 5
X 5 00000030 6
D 0 0 1 0 12345678 1 0 11111111
D 1 1 1 0 00000010 1 0 00000020
D 2 2 1 0 f0f0f0f0 1 0 ff00ff00
D 3 3 1 0 0f0f0000 1 0 000000ff
D 4 4 1 0 aaaa5555 1 0 ffff0000
D 5 5 1 0 00000003 1 0 00000024
I 4 0
# Forwarding through CDB 0, the last one captures in its dispatch cycle
X 6 00000123 0
X 7 00000120 0
X 8 0000fedf 0
D 0 6 1 0 00000100 1 0 00000023
D 1 7 0 6 00000000 1 0 00000003
I 2 0
D 4 8 1 0 0000ffff 0 7 00000000
I 4 0
# Three entries wait on the external bus, then wake together and issue oldest first
D 0 9 0 c 00000000 1 0 00000001
D 3 a 0 c 00000000 1 0 80000000
D 5 b 0 c 00000000 1 0 00000008
I 3 0
X 9 00abcdf0 7
X a 80abcdef 8
X b abcdef00 9
E c 00abcdef
I 5 0
# Eight waiting entries fill the station, one broadcast drains it
D 0 0 1 0 00000000 0 d 00000000
D 0 1 1 0 00000001 0 d 00000000
D 0 2 1 0 00000002 0 d 00000000
D 0 3 1 0 00000003 0 d 00000000
D 0 4 1 0 00000004 0 d 00000000
D 0 5 1 0 00000005 0 d 00000000
D 0 6 1 0 00000006 0 d 00000000
D 0 7 1 0 00000007 0 d 00000000
I 2 1
X 0 10000000 a
X 1 10000001 b
X 2 10000002 c
X 3 10000003 d
X 4 10000004 e
X 5 10000005 f
X 6 10000006 10
X 7 10000007 11
E d 10000000
I 2 0
I c 0
# Flush drops two waiting entries and the result in flight
D 0 8 0 e 00000000 1 0 00000001
D 2 9 0 e 00000000 1 0 0000ffff
D 0 a 1 0 00000001 1 0 00000001
F
I 2 0
E e 12345678
I 4 0
X 3 00000003 0
D 3 3 1 0 00000001 1 0 00000002
I 4 0

// ==== bench/rs_tb.sv ====
// --------------------------------------------------
// Reservation station testbench
// Replays the pattern file on falling clock edges
// and scoreboards CDB 0 results by their tag
// --------------------------------------------------
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_tb;
    import rs_pkg::*;

    localparam int NUM_TAGS = 1 << `RS_TAG_WIDTH;

    logic                      clk;
    logic                      rst_n;
    logic                      flush;
    logic                      disp_en;
    rs_opcode_e                disp_opcode;
    logic [`RS_TAG_WIDTH-1:0]  disp_tag  [2];
    logic [`RS_DATA_WIDTH-1:0] disp_data [2];
    logic                      disp_rdy  [2];
    logic [`RS_TAG_WIDTH-1:0]  disp_dst;
    logic                      ext_en;
    logic [`RS_TAG_WIDTH-1:0]  ext_tag;
    logic [`RS_DATA_WIDTH-1:0] ext_data;
    logic                      full;
    logic                      cdb_en;
    logic [`RS_TAG_WIDTH-1:0]  cdb_tag;
    logic [`RS_DATA_WIDTH-1:0] cdb_data;

    // Scoreboard indexed by destination tag
    // A nonzero sequence number fixes the result's place in the ordered stream
    logic                      exp_pending [NUM_TAGS];
    logic [`RS_DATA_WIDTH-1:0] exp_data    [NUM_TAGS];
    logic [31:0]               exp_seq     [NUM_TAGS];
    logic [31:0]               next_seq;
    int                        cycle_count;
    int                        cycle_limit;
    int                        line_count;
    int                        missing;
    int                        fd;
    int                        nread;
    logic [7:0]                cmd;
    logic [31:0]               fld [8];
    string                     line;

    rs_tb_clk u_clk (
        .o_clk (clk)
    );

    rs_core dut0 (
        .i_clk                 (clk),
        .i_rst_n               (rst_n),
        .i_flush               (flush),
        .i_dispatch_en         (disp_en),
        .i_dispatch_opcode     (disp_opcode),
        .i_dispatch_src_tag_a  (disp_tag[0]),
        .i_dispatch_src_tag_b  (disp_tag[1]),
        .i_dispatch_src_data_a (disp_data[0]),
        .i_dispatch_src_data_b (disp_data[1]),
        .i_dispatch_src_rdy_a  (disp_rdy[0]),
        .i_dispatch_src_rdy_b  (disp_rdy[1]),
        .i_dispatch_dst_tag    (disp_dst),
        .i_ext_cdb_en          (ext_en),
        .i_ext_cdb_tag         (ext_tag),
        .i_ext_cdb_data        (ext_data),
        .o_full                (full),
        .o_cdb_en              (cdb_en),
        .o_cdb_tag             (cdb_tag),
        .o_cdb_data            (cdb_data)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    // Move to the next falling edge and drop every one-cycle strobe
    task automatic next_cycle();
        @(negedge clk);
        disp_en = 1'b0;
        ext_en  = 1'b0;
        flush   = 1'b0;
    endtask

    // CDB 0 only changes after a rising edge, so the falling edge sees each pulse once
    always @(negedge clk) begin
        if (rst_n && cdb_en) begin
            if (!exp_pending[cdb_tag]) begin
                abort_run($sformatf("CDB 0 result with unexpected or repeated tag 0x%h",
                                    cdb_tag));
            end
            check_value("o_cdb_data", cdb_data, exp_data[cdb_tag]);
            if (exp_seq[cdb_tag] != 0) begin
                check_value("o_cdb order", exp_seq[cdb_tag], next_seq);
                next_seq = next_seq + 1;
            end
            exp_pending[cdb_tag] = 1'b0;
        end
    end

    // The limit scales with the length of the pattern file
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            abort_run("Timeout: the patterns did not finish within the cycle limit");
        end
    end

    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        disp_en     = 1'b0;
        disp_opcode = OP_ADD;
        disp_tag    = '{default: '0};
        disp_data   = '{default: '0};
        disp_rdy    = '{default: 1'b0};
        disp_dst    = '0;
        ext_en      = 1'b0;
        ext_tag     = '0;
        ext_data    = '0;
        next_seq    = 32'd1;
        cycle_count = 0;
        line_count  = 0;
        foreach (exp_pending[t]) begin
            exp_pending[t] = 1'b0;
            exp_data[t]    = '0;
            exp_seq[t]     = '0;
        end

        // First pass only counts lines for the cycle limit
        fd = $fopen("bench/rs_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open bench/rs_patterns.txt");
        end
        while ($fgets(line, fd) != 0) begin
            line_count++;
        end
        $fclose(fd);
        cycle_limit = 20 * line_count + 50;
        fd = $fopen("bench/rs_patterns.txt", "r");

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": begin
                    void'($fgets(line, fd));
                end
                "D": begin
                    nread = $fscanf(fd, " %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                                    fld[3], fld[4], fld[5], fld[6], fld[7]);
                    if (nread != 8) begin
                        abort_run("Malformed dispatch line in the pattern file");
                    end
                    next_cycle();
                    if (full) begin
                        abort_run("The patterns dispatch while the station reports full");
                    end
                    disp_en      = 1'b1;
                    disp_opcode  = rs_opcode_e'(fld[0][2:0]);
                    disp_dst     = fld[1][`RS_TAG_WIDTH-1:0];
                    disp_rdy[0]  = fld[2][0];
                    disp_tag[0]  = fld[3][`RS_TAG_WIDTH-1:0];
                    disp_data[0] = fld[4];
                    disp_rdy[1]  = fld[5][0];
                    disp_tag[1]  = fld[6][`RS_TAG_WIDTH-1:0];
                    disp_data[1] = fld[7];
                end
                "E": begin
                    nread = $fscanf(fd, " %h %h", fld[0], fld[1]);
                    if (nread != 2) begin
                        abort_run("Malformed broadcast line in the pattern file");
                    end
                    next_cycle();
                    ext_en   = 1'b1;
                    ext_tag  = fld[0][`RS_TAG_WIDTH-1:0];
                    ext_data = fld[1];
                end
                "F": begin
                    next_cycle();
                    flush = 1'b1;
                end
                "I": begin
                    nread = $fscanf(fd, " %h %h", fld[0], fld[1]);
                    if (nread != 2) begin
                        abort_run("Malformed idle line in the pattern file");
                    end
                    repeat (fld[0]) next_cycle();
                    // Full level as it stands after the idle cycles
                    check_value("o_full", {31'd0, full}, fld[1]);
                end
                "X": begin
                    nread = $fscanf(fd, " %h %h %h", fld[0], fld[1], fld[2]);
                    if (nread != 3) begin
                        abort_run("Malformed expectation line in the pattern file");
                    end
                    if (exp_pending[fld[0][`RS_TAG_WIDTH-1:0]]) begin
                        abort_run("An expectation names a tag that is still pending");
                    end
                    exp_pending[fld[0][`RS_TAG_WIDTH-1:0]] = 1'b1;
                    exp_data[fld[0][`RS_TAG_WIDTH-1:0]]    = fld[1];
                    exp_seq[fld[0][`RS_TAG_WIDTH-1:0]]     = fld[2];
                end
                default: begin
                    abort_run("Unknown command letter in the pattern file");
                end
            endcase
        end
        $fclose(fd);

        missing = 0;
        foreach (exp_pending[t]) begin
            if (exp_pending[t]) begin
                $display("Result for tag 0x%h never appeared on CDB 0", t);
                missing++;
            end
        end
        if (missing != 0) begin
            abort_run("Expected results are missing at the end of the patterns");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== bench/rs_tb_clk.sv ====
// ------------------------------------------------
// Testbench clock
// Free-running clock with a 4 ns period
// ------------------------------------------------
`timescale 1ns/1ps

module rs_tb_clk (
    output logic o_clk
);

    localparam int HALF_PERIOD_NS = 2;

    initial o_clk = 1'b0;

    // Rising edges at 2 ns, 6 ns, 10 ns and so on
    always #(HALF_PERIOD_NS) o_clk = ~o_clk;

endmodule

// ==== design/rs_alu.sv ====
// ------------------------------------------------
// Integer ALU
// One registered stage, result broadcast on CDB 0
// ------------------------------------------------
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_alu (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_flush,
    issue_if.receiver     iss,
    output rs_pkg::cdb_t  o_cdb
);
    import rs_pkg::*;

    logic [`RS_DATA_WIDTH-1:0] result;
    logic                      cdb_en_r;
    logic [`RS_TAG_WIDTH-1:0]  cdb_tag_r;
    logic [`RS_DATA_WIDTH-1:0] cdb_data_r;

    always_comb begin
        case (iss.opcode)
            OP_ADD:  result = iss.src_a + iss.src_b;
            OP_SUB:  result = iss.src_a - iss.src_b;
            OP_AND:  result = iss.src_a & iss.src_b;
            OP_OR:   result = iss.src_a | iss.src_b;
            OP_XOR:  result = iss.src_a ^ iss.src_b;
            // Shift amount is the low five bits of B
            OP_SLL:  result = iss.src_a << iss.src_b[4:0];
            default: result = '0;
        endcase
    end

    // Strobe lasts one cycle, a flush drops the result in flight
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            cdb_en_r <= 1'b0;
        end else begin
            cdb_en_r <= iss.en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (iss.en) begin
            cdb_tag_r  <= iss.dst_tag;
            cdb_data_r <= result;
        end
    end

    assign o_cdb = '{en: cdb_en_r, tag: cdb_tag_r, data: cdb_data_r};

endmodule

// ==== design/rs_cfg.svh ====
// ------------------------------------------------
// Reservation station configuration
// Operand, tag and index widths plus the station
// depth and the number of result buses
// ------------------------------------------------
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// Operand and result width
`define RS_DATA_WIDTH 32
`define RS_TAG_WIDTH 4
`define RS_DEPTH 8
// Wide enough for an entry index and for an age
`define RS_IDX_WIDTH 3
`define RS_CDB_DEPTH 2
`endif

// ==== design/rs_core.sv ====
// ------------------------------------------------
// Issue subsystem top level
// Station and ALU, with the ALU result fed back
// as CDB 0 and an external bus as CDB 1
// ------------------------------------------------
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_core (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_flush,
    input  logic                      i_dispatch_en,
    input  rs_pkg::rs_opcode_e        i_dispatch_opcode,
    input  logic [`RS_TAG_WIDTH-1:0]  i_dispatch_src_tag_a,
    input  logic [`RS_TAG_WIDTH-1:0]  i_dispatch_src_tag_b,
    input  logic [`RS_DATA_WIDTH-1:0] i_dispatch_src_data_a,
    input  logic [`RS_DATA_WIDTH-1:0] i_dispatch_src_data_b,
    input  logic                      i_dispatch_src_rdy_a,
    input  logic                      i_dispatch_src_rdy_b,
    input  logic [`RS_TAG_WIDTH-1:0]  i_dispatch_dst_tag,
    input  logic                      i_ext_cdb_en,
    input  logic [`RS_TAG_WIDTH-1:0]  i_ext_cdb_tag,
    input  logic [`RS_DATA_WIDTH-1:0] i_ext_cdb_data,
    output logic                      o_full,
    output logic                      o_cdb_en,
    output logic [`RS_TAG_WIDTH-1:0]  o_cdb_tag,
    output logic [`RS_DATA_WIDTH-1:0] o_cdb_data
);
    import rs_pkg::*;

    cdb_t cdb [`RS_CDB_DEPTH];
    cdb_t alu_cdb;

    dispatch_if disp_bus ();
    issue_if    iss_bus ();

    assign disp_bus.en          = i_dispatch_en;
    assign disp_bus.opcode      = i_dispatch_opcode;
    assign disp_bus.src_tag[0]  = i_dispatch_src_tag_a;
    assign disp_bus.src_tag[1]  = i_dispatch_src_tag_b;
    assign disp_bus.src_data[0] = i_dispatch_src_data_a;
    assign disp_bus.src_data[1] = i_dispatch_src_data_b;
    assign disp_bus.src_rdy[0]  = i_dispatch_src_rdy_a;
    assign disp_bus.src_rdy[1]  = i_dispatch_src_rdy_b;
    assign disp_bus.dst_tag     = i_dispatch_dst_tag;

    // CDB 0 is the ALU result register, CDB 1 stands in for a load unit
    assign cdb[0] = alu_cdb;
    assign cdb[1] = '{en: i_ext_cdb_en, tag: i_ext_cdb_tag, data: i_ext_cdb_data};

    rs_station u_station (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_cdb   (cdb),
        .disp    (disp_bus),
        .iss     (iss_bus),
        .o_full  (o_full)
    );

    rs_alu u_alu (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .iss     (iss_bus),
        .o_cdb   (alu_cdb)
    );

    assign o_cdb_en   = alu_cdb.en;
    assign o_cdb_tag  = alu_cdb.tag;
    assign o_cdb_data = alu_cdb.data;

endmodule

// ==== design/rs_entry.sv ====
// ------------------------------------------------
// Reservation station entry
// Holds one instruction, snoops the result buses
// for missing operands and tracks its relative age
// ------------------------------------------------
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_entry (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_flush,
    input  rs_pkg::cdb_t              i_cdb [`RS_CDB_DEPTH],
    input  logic                      i_dispatch_en,
    dispatch_if.receiver              disp,
    input  logic                      i_issue_en,
    input  logic                      i_dispatching,
    input  logic                      i_issuing,
    input  logic [`RS_IDX_WIDTH-1:0]  i_issue_age,
    output logic                      o_empty,
    output logic                      o_ready,
    output logic [`RS_IDX_WIDTH-1:0]  o_age,
    output rs_pkg::rs_opcode_e        o_opcode,
    output logic [`RS_DATA_WIDTH-1:0] o_src_data [2],
    output logic [`RS_TAG_WIDTH-1:0]  o_dst_tag
);
    import rs_pkg::*;

    logic                      empty_r;
    logic [`RS_IDX_WIDTH-1:0]  age_r;
    logic [`RS_IDX_WIDTH-1:0]  age_next;
    rs_opcode_e                opcode_r;
    logic [`RS_TAG_WIDTH-1:0]  dst_tag_r;
    logic [`RS_TAG_WIDTH-1:0]  src_tag_r  [2];
    logic [`RS_DATA_WIDTH-1:0] src_data_r [2];
    logic                      src_rdy_r  [2];
    logic [`RS_TAG_WIDTH-1:0]  tag_base   [2];
    logic                      rdy_base   [2];
    logic [`RS_DATA_WIDTH-1:0] data_next  [2];
    logic                      rdy_next   [2];
    logic [`RS_CDB_DEPTH-1:0]  cdb_hit    [2];

    // Operand capture starts from the dispatch fields when this entry is written
    // and from the stored state otherwise, so a result broadcast in the dispatch
    // cycle is not lost
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            tag_base[s]  = i_dispatch_en ? disp.src_tag[s] : src_tag_r[s];
            rdy_base[s]  = i_dispatch_en ? disp.src_rdy[s] : src_rdy_r[s];
            data_next[s] = i_dispatch_en ? disp.src_data[s] : src_data_r[s];
            rdy_next[s]  = rdy_base[s];
            for (int c = 0; c < `RS_CDB_DEPTH; c++) begin
                // A ready operand keeps its value whatever the buses carry
                cdb_hit[s][c] = i_cdb[c].en && !rdy_base[s] && (i_cdb[c].tag == tag_base[s]);
                if (cdb_hit[s][c]) begin
                    data_next[s] = i_cdb[c].data;
                    rdy_next[s]  = 1'b1;
                end
            end
        end
    end

    // Dispatch zeroes the age, other entries move relative to dispatch and issue
    always_comb begin
        case ({i_dispatching, i_issuing})
            2'b01:   age_next = (age_r > i_issue_age) ? age_r - 1'b1 : age_r;
            2'b10:   age_next = age_r + 1'b1;
            2'b11:   age_next = (age_r < i_issue_age) ? age_r + 1'b1 : age_r;
            default: age_next = age_r;
        endcase
        if (i_dispatch_en) begin
            age_next = '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            empty_r   <= 1'b1;
            age_r     <= '0;
            src_rdy_r <= '{1'b0, 1'b0};
        end else begin
            // Issue and flush free the slot, a new dispatch claims it
            if (i_flush || i_issue_en) begin
                empty_r <= 1'b1;
            end else if (i_dispatch_en) begin
                empty_r <= 1'b0;
            end
            age_r     <= age_next;
            src_rdy_r <= rdy_next;
        end
    end

    always_ff @(posedge i_clk) begin
        src_data_r <= data_next;
        if (i_dispatch_en) begin
            opcode_r  <= disp.opcode;
            src_tag_r <= disp.src_tag;
            dst_tag_r <= disp.dst_tag;
        end
    end

    // Ready once occupied and holding both operands
    assign o_ready    = !empty_r && src_rdy_r[0] && src_rdy_r[1];
    assign o_empty    = empty_r;
    assign o_age      = age_r;
    assign o_opcode   = opcode_r;
    assign o_src_data = src_data_r;
    assign o_dst_tag  = dst_tag_r;

    // The ALU bus and the external bus must never wake the same operand together
    a_cdb_unique_tag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(cdb_hit[0]) && $onehot0(cdb_hit[1]));

endmodule

// ==== design/rs_ifs.sv ====
// ------------------------------------------------
// Dispatch and issue interfaces
// Dispatch carries an instruction into the station,
// issue carries the selected entry to the ALU
// ------------------------------------------------
`timescale 1ns/1ps
`include "rs_cfg.svh"

interface dispatch_if;
    import rs_pkg::*;

    logic                      en;
    rs_opcode_e                opcode;
    // Index 0 is operand A, index 1 is operand B
    logic [`RS_TAG_WIDTH-1:0]  src_tag  [2];
    logic [`RS_DATA_WIDTH-1:0] src_data [2];
    logic                      src_rdy  [2];
    logic [`RS_TAG_WIDTH-1:0]  dst_tag;

    modport sender   (output en, opcode, src_tag, src_data, src_rdy, dst_tag);
    modport receiver (input en, opcode, src_tag, src_data, src_rdy, dst_tag);
endinterface

interface issue_if;
    import rs_pkg::*;

    // The strobe lasts one cycle and the ALU accepts an issue every cycle
    logic                      en;
    rs_opcode_e                opcode;
    logic [`RS_DATA_WIDTH-1:0] src_a;
    logic [`RS_DATA_WIDTH-1:0] src_b;
    logic [`RS_TAG_WIDTH-1:0]  dst_tag;

    modport sender   (output en, opcode, src_a, src_b, dst_tag);
    modport receiver (input en, opcode, src_a, src_b, dst_tag);
endinterface

// ==== design/rs_issue_select.sv ====
// ------------------------------------------------
// Issue select
// Finds the oldest ready entry of the station
// ------------------------------------------------
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_issue_select (
    input  logic [`RS_DEPTH-1:0]     i_ready,
    input  logic [`RS_IDX_WIDTH-1:0] i_age [`RS_DEPTH],
    output logic                     o_valid,
    output logic [`RS_IDX_WIDTH-1:0] o_idx,
    output logic [`RS_IDX_WIDTH-1:0] o_age
);

    // Larger age means older, and occupied entries never share an age,
    // so the scan order does not change the winner
    always_comb begin
        o_valid = 1'b0;
        o_idx   = '0;
        o_age   = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (i_ready[i] && (!o_valid || (i_age[i] > o_age))) begin
                o_valid = 1'b1;
                o_idx   = i[`RS_IDX_WIDTH-1:0];
                o_age   = i_age[i];
            end
        end
    end

endmodule

// ==== design/rs_pkg.sv ====
// ------------------------------------------------
// Reservation station types
// ALU opcodes and the common data bus word
// ------------------------------------------------
`include "rs_cfg.svh"

package rs_pkg;

    // Integer operations the single ALU understands
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL
    } rs_opcode_e;

    // One result bus: strobe, producer tag and result value
    typedef struct packed {
        logic                      en;
        logic [`RS_TAG_WIDTH-1:0]  tag;
        logic [`RS_DATA_WIDTH-1:0] data;
    } cdb_t;

endpackage

// ==== design/rs_station.sv ====
// ------------------------------------------------
// Reservation station
// Allocates free entries on dispatch, keeps ages
// in order and muxes the oldest ready entry out
// ------------------------------------------------
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_station (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_flush,
    input  rs_pkg::cdb_t  i_cdb [`RS_CDB_DEPTH],
    dispatch_if.receiver  disp,
    issue_if.sender       iss,
    output logic          o_full
);
    import rs_pkg::*;

    logic [`RS_DEPTH-1:0]      empty;
    logic [`RS_DEPTH-1:0]      ready;
    logic [`RS_DEPTH-1:0]      dispatch_en;
    logic [`RS_DEPTH-1:0]      issue_en;
    logic [`RS_IDX_WIDTH-1:0]  age      [`RS_DEPTH];
    rs_opcode_e                opcode   [`RS_DEPTH];
    logic [`RS_DATA_WIDTH-1:0] src_data [`RS_DEPTH][2];
    logic [`RS_TAG_WIDTH-1:0]  dst_tag  [`RS_DEPTH];
    logic                      dispatching;
    logic                      sel_valid;
    logic [`RS_IDX_WIDTH-1:0]  sel_idx;
    logic [`RS_IDX_WIDTH-1:0]  sel_age;

    assign o_full      = ~|empty;
    assign dispatching = disp.en && !o_full;

    // Lowest empty slot takes the dispatch, the rest see only the age update
    always_comb begin
        logic found;
        found       = 1'b0;
        dispatch_en = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (empty[i] && !found) begin
                dispatch_en[i] = dispatching;
                found          = 1'b1;
            end
            issue_en[i] = sel_valid && (sel_idx == i[`RS_IDX_WIDTH-1:0]);
        end
    end

    for (genvar g = 0; g < `RS_DEPTH; g++) begin : g_entry
        rs_entry u_entry (
            .i_clk         (i_clk),
            .i_rst_n       (i_rst_n),
            .i_flush       (i_flush),
            .i_cdb         (i_cdb),
            .i_dispatch_en (dispatch_en[g]),
            .disp          (disp),
            .i_issue_en    (issue_en[g]),
            .i_dispatching (dispatching),
            .i_issuing     (sel_valid),
            .i_issue_age   (sel_age),
            .o_empty       (empty[g]),
            .o_ready       (ready[g]),
            .o_age         (age[g]),
            .o_opcode      (opcode[g]),
            .o_src_data    (src_data[g]),
            .o_dst_tag     (dst_tag[g])
        );
    end

    rs_issue_select u_select (
        .i_ready (ready),
        .i_age   (age),
        .o_valid (sel_valid),
        .o_idx   (sel_idx),
        .o_age   (sel_age)
    );

    // Selected entry goes to the ALU in the same cycle
    assign iss.en      = sel_valid;
    assign iss.opcode  = opcode[sel_idx];
    assign iss.src_a   = src_data[sel_idx][0];
    assign iss.src_b   = src_data[sel_idx][1];
    assign iss.dst_tag = dst_tag[sel_idx];

    // The dispatcher has to respect the full level
    a_no_dispatch_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        disp.en |-> !o_full);

    // Without a flush at most one occupied entry is freed per cycle
    a_single_issue: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_flush |=> $onehot0(empty & ~$past(empty)));

endmodule

// ==== files.f ====
+incdir+design
design/rs_pkg.sv
design/rs_ifs.sv
design/rs_entry.sv
design/rs_issue_select.sv
design/rs_station.sv
design/rs_alu.sv
design/rs_core.sv
bench/rs_tb_clk.sv
bench/rs_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module rs_tb -o rs_sim &&
./obj_dir/rs_sim ||
exit 1
